//--- mdu_issue.f
source/mdu_pkg.sv
source/iq_entry.sv
source/mdu_iq.sv
source/mdu_unit.sv
source/mdu_issue_top.sv
tb/tb_mdu_issue.sv

//--- run_mdu_issue.sh
#!/bin/sh
# compile and run the mdu_issue testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f mdu_issue.f --top-module tb_mdu_issue -o tb_mdu_issue; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/tb_mdu_issue)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- tb/tb_mdu_issue.sv
`timescale 1ns/1ns

module tb_mdu_issue;
    import mdu_pkg::*;

    localparam int CYCLE_LIMIT = 20000;

    logic    clk;
    logic    reset;
    logic    flush;
    logic    disp_valid [DISPATCH_W];
    mdu_op_e disp_op [DISPATCH_W];
    rob_id_t disp_rob [DISPATCH_W];
    word_t   src_data [DISPATCH_W][2];
    rob_id_t src_tag [DISPATCH_W][2];
    logic    src_ready [DISPATCH_W][2];
    logic    disp_ready;
    logic    cdb_valid [CDB_W];
    rob_id_t cdb_rob [CDB_W];
    word_t   cdb_data [CDB_W];
    logic    res_valid;
    rob_id_t res_rob;
    word_t   res_data;
    logic    res_ready;

    // expected results in dispatch order
    rob_id_t exp_rob [$];
    word_t   exp_val [$];

    logic [31:0] lfsr_state = 32'hf5f1;
    rob_id_t     next_rob = '0;
    logic        stall_mode = 1'b0;
    logic        ready_level = 1'b1;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic        held = 1'b0;
    rob_id_t     held_rob;
    word_t       held_data;

    word_t corner [6] = '{32'h0000_0003, 32'hffff_fff9, 32'h8000_0000,
                          32'hffff_ffff, 32'h7fff_ffff, 32'h0000_0000};

    mdu_issue_top u_dut (
        .clk               (clk),
        .reset_i           (reset),
        .flush_i           (flush),
        .dispatch_valid_i  (disp_valid),
        .dispatch_op_i     (disp_op),
        .dispatch_rob_id_i (disp_rob),
        .src_data_i        (src_data),
        .src_tag_i         (src_tag),
        .src_ready_i       (src_ready),
        .dispatch_ready_o  (disp_ready),
        .cdb_valid_i       (cdb_valid),
        .cdb_rob_id_i      (cdb_rob),
        .cdb_data_i        (cdb_data),
        .result_valid_o    (res_valid),
        .result_rob_id_o   (res_rob),
        .result_data_o     (res_data),
        .result_ready_i    (res_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // random bits and reference model
    // ------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic word_t expected_result(input mdu_op_e op, input word_t a, input word_t b);
        logic signed [63:0] sp;
        logic [63:0]        up;
        logic               ovf;
        logic signed [31:0] sq;
        logic signed [31:0] sr;
        sp  = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        up  = {32'h0, a} * {32'h0, b};
        ovf = a == 32'h8000_0000 && b == 32'hffff_ffff;
        // signed quotient and remainder where the division is defined
        sq  = '0;
        sr  = '0;
        if (b != '0 && !ovf) begin
            sq = $signed(a) / $signed(b);
            sr = $signed(a) % $signed(b);
        end
        case (op)
            MDU_MUL:   return sp[31:0];
            MDU_MULH:  return sp[63:32];
            MDU_MULHU: return up[63:32];
            MDU_DIV:   return (b == '0) ? '1 : (ovf ? a : sq);
            MDU_DIVU:  return (b == '0) ? '1 : a / b;
            MDU_REM:   return (b == '0) ? a : (ovf ? '0 : sr);
            MDU_REMU:  return (b == '0) ? a : a % b;
            default:   return '0;
        endcase
    endfunction

    // ------------------------------
    // drive helpers
    // ------------------------------
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        for (int d = 0; d < DISPATCH_W; d++) begin
            disp_valid[d] = 1'b0;
        end
        for (int k = 0; k < CDB_W; k++) begin
            cdb_valid[k] = 1'b0;
        end
        if (stall_mode) begin
            rand_bits(1, r);
            res_ready = r[0];
        end else begin
            res_ready = ready_level;
        end
    endtask

    task automatic wait_dispatch_ready();
        next_cycle();
        while (!disp_ready) begin
            next_cycle();
        end
    endtask

    // waiting operands get a wrong value so only a capture can fix them
    task automatic put_slot(input int s, input mdu_op_e op, input word_t a, input word_t b,
                            input logic rdy_a, input logic rdy_b,
                            input rob_id_t tag_a, input rob_id_t tag_b);
        disp_valid[s]   = 1'b1;
        disp_op[s]      = op;
        disp_rob[s]     = next_rob;
        src_data[s][0]  = rdy_a ? a : ~a;
        src_data[s][1]  = rdy_b ? b : ~b;
        src_ready[s][0] = rdy_a;
        src_ready[s][1] = rdy_b;
        src_tag[s][0]   = tag_a;
        src_tag[s][1]   = tag_b;
        exp_rob.push_back(next_rob);
        exp_val.push_back(expected_result(op, a, b));
        next_rob = next_rob + 5'd1;
    endtask

    task automatic put_ready(input int s, input mdu_op_e op, input word_t a, input word_t b);
        put_slot(s, op, a, b, 1'b1, 1'b1, '0, '0);
    endtask

    task automatic cdb_send(input int k, input rob_id_t tag, input word_t data);
        cdb_valid[k] = 1'b1;
        cdb_rob[k]   = tag;
        cdb_data[k]  = data;
    endtask

    task automatic pick_operands(input int i, output word_t a, output word_t b);
        if (i < 6) begin
            a = corner[i];
            b = corner[(i + 1) % 6];
        end else begin
            rand_bits(32, a);
            rand_bits(32, b);
        end
    endtask

    task automatic wait_drain();
        while (exp_rob.size() > 0) begin
            next_cycle();
        end
    endtask

    // slot 0 alone, then a pair, then slot 1 alone
    task automatic run_ops(input mdu_op_e op, input int count);
        word_t a;
        word_t b;
        int    i;
        int    grp;
        i   = 0;
        grp = 0;
        while (i < count) begin
            wait_dispatch_ready();
            pick_operands(i, a, b);
            if (grp % 3 == 2) begin
                put_ready(1, op, a, b);
            end else begin
                put_ready(0, op, a, b);
            end
            i++;
            if (grp % 3 == 1 && i < count) begin
                pick_operands(i, a, b);
                put_ready(1, op, a, b);
                i++;
            end
            grp++;
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic test_multiply();
        run_ops(MDU_MUL, 10);
        run_ops(MDU_MULH, 10);
        run_ops(MDU_MULHU, 10);
        wait_drain();
        $display("multiply test finished, errors so far %0d", error_count);
    endtask

    task automatic test_divide();
        run_ops(MDU_DIV, 10);
        run_ops(MDU_DIVU, 10);
        run_ops(MDU_REM, 10);
        run_ops(MDU_REMU, 10);
        wait_drain();
        $display("divide test finished, errors so far %0d", error_count);
    endtask

    task automatic test_wakeup();
        word_t v [6];
        for (int k = 0; k < 6; k++) begin
            rand_bits(32, v[k]);
        end
        wait_dispatch_ready();
        put_slot(0, MDU_MUL, v[0], 32'h11, 1'b0, 1'b1, 5'd20, '0);
        put_slot(1, MDU_DIVU, 32'h1234_5678, v[1], 1'b1, 1'b0, '0, 5'd21);
        wait_dispatch_ready();
        put_slot(0, MDU_REM, v[2], v[3], 1'b0, 1'b0, 5'd22, 5'd23);
        wait_dispatch_ready();
        put_slot(0, MDU_MULHU, v[4], v[5], 1'b0, 1'b0, 5'd24, 5'd25);
        // broadcast lands in the dispatch cycle
        cdb_send(0, 5'd24, v[4]);
        // remaining producers in reverse order
        next_cycle();
        cdb_send(0, 5'd25, v[5]);
        cdb_send(1, 5'd23, v[3]);
        next_cycle();
        cdb_send(0, 5'd22, v[2]);
        cdb_send(1, 5'd21, v[1]);
        next_cycle();
        cdb_send(1, 5'd20, v[0]);
        wait_drain();
        $display("wakeup test finished, errors so far %0d", error_count);
    endtask

    task automatic test_backpressure();
        stall_mode = 1'b1;
        run_ops(MDU_MULH, 8);
        run_ops(MDU_DIV, 8);
        wait_drain();
        stall_mode = 1'b0;
        $display("back-pressure test finished, errors so far %0d", error_count);
    endtask

    task automatic test_full_queue();
        word_t   a;
        word_t   b;
        mdu_op_e op;
        int      accepted;
        accepted    = 0;
        ready_level = 1'b0;
        next_cycle();
        while (disp_ready && accepted < 3 * IQ_SIZE) begin
            pick_operands(6, a, b);
            if (accepted % 2 == 1) begin
                op = MDU_DIVU;
            end else begin
                op = MDU_MUL;
            end
            put_ready(0, op, a, b);
            accepted++;
            next_cycle();
        end
        // queue short of a free pair, plus operand register and unit
        if (accepted < IQ_SIZE - 1 || accepted > IQ_SIZE + 1) begin
            $display("CHECK FAILED at %0t: queue accepted %0d before dispatch_ready fell",
                     $time, accepted);
            error_count++;
        end
        repeat (5) next_cycle();
        if (disp_ready) begin
            $display("CHECK FAILED at %0t: dispatch_ready rose while the queue is full", $time);
            error_count++;
        end
        ready_level = 1'b1;
        wait_drain();
        $display("full queue test finished, %0d accepted, errors so far %0d",
                 accepted, error_count);
    endtask

    task automatic test_flush();
        word_t a;
        word_t b;
        ready_level = 1'b0;
        wait_dispatch_ready();
        pick_operands(6, a, b);
        put_ready(0, MDU_DIVU, a, b | 32'h1);
        wait_dispatch_ready();
        pick_operands(6, a, b);
        put_ready(0, MDU_MUL, a, b);
        put_ready(1, MDU_REM, b, a);
        repeat (10) next_cycle();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        // aborted work never returns
        exp_rob.delete();
        exp_val.delete();
        ready_level = 1'b1;
        repeat (DIV_STEPS + 8) begin
            if (res_valid || !disp_ready) begin
                $display("CHECK FAILED at %0t: result_valid %0b dispatch_ready %0b after flush",
                         $time, res_valid, disp_ready);
                error_count++;
            end
            next_cycle();
        end
        wait_dispatch_ready();
        pick_operands(6, a, b);
        put_ready(0, MDU_DIV, a, b);
        wait_drain();
        $display("flush test finished, errors so far %0d", error_count);
    endtask

    // ------------------------------
    // result monitor and timeout
    // ------------------------------
    always @(negedge clk) begin
        if (reset || flush) begin
            held = 1'b0;
        end else begin
            if (held && (!res_valid || res_rob != held_rob || res_data != held_data)) begin
                $display("CHECK FAILED at %0t: result for rob %0d changed while stalled",
                         $time, held_rob);
                error_count++;
            end
            if (res_valid && res_ready) begin
                if (exp_rob.size() == 0) begin
                    $display("result for rob %0d arrived with no instruction outstanding",
                             res_rob);
                    error_count++;
                end else begin
                    check_count++;
                    if (res_rob != exp_rob[0] || res_data != exp_val[0]) begin
                        $display("CHECK FAILED at %0t: rob %0d expected %h (rob %0d) got %h",
                                 $time, res_rob, exp_val[0], exp_rob[0], res_data);
                        error_count++;
                    end
                    void'(exp_rob.pop_front());
                    void'(exp_val.pop_front());
                end
            end
            held      = res_valid && !res_ready;
            held_rob  = res_rob;
            held_data = res_data;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        reset     = 1'b1;
        flush     = 1'b0;
        res_ready = 1'b1;
        for (int d = 0; d < DISPATCH_W; d++) begin
            disp_valid[d] = 1'b0;
            disp_op[d]    = MDU_MUL;
            disp_rob[d]   = '0;
            for (int s = 0; s < 2; s++) begin
                src_data[d][s]  = '0;
                src_tag[d][s]   = '0;
                src_ready[d][s] = 1'b0;
            end
        end
        for (int k = 0; k < CDB_W; k++) begin
            cdb_valid[k] = 1'b0;
            cdb_rob[k]   = '0;
            cdb_data[k]  = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        if (!disp_ready || res_valid) begin
            $display("CHECK FAILED at %0t: wrong dispatch_ready or result_valid after reset",
                     $time);
            error_count++;
        end
        test_multiply();
        test_divide();
        test_wakeup();
        test_backpressure();
        test_full_queue();
        test_flush();
        repeat (4) next_cycle();
        $display("%0d results checked, %0d errors, %0d cycles",
                 check_count, error_count, cycle_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- source/mdu_issue_top.sv
`timescale 1ns/1ns

module mdu_issue_top (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             flush_i,
    input  logic             dispatch_valid_i [mdu_pkg::DISPATCH_W],
    input  mdu_pkg::mdu_op_e dispatch_op_i [mdu_pkg::DISPATCH_W],
    input  mdu_pkg::rob_id_t dispatch_rob_id_i [mdu_pkg::DISPATCH_W],
    input  mdu_pkg::word_t   src_data_i [mdu_pkg::DISPATCH_W][2],
    input  mdu_pkg::rob_id_t src_tag_i [mdu_pkg::DISPATCH_W][2],
    input  logic             src_ready_i [mdu_pkg::DISPATCH_W][2],
    output logic             dispatch_ready_o,
    input  logic             cdb_valid_i [mdu_pkg::CDB_W],
    input  mdu_pkg::rob_id_t cdb_rob_id_i [mdu_pkg::CDB_W],
    input  mdu_pkg::word_t   cdb_data_i [mdu_pkg::CDB_W],
    output logic             result_valid_o,
    output mdu_pkg::rob_id_t result_rob_id_o,
    output mdu_pkg::word_t   result_data_o,
    input  logic             result_ready_i
);
    import mdu_pkg::*;

    // operand register to unit
    logic    issue_valid;
    logic    issue_ready;
    mdu_op_e issue_op;
    rob_id_t issue_rob_id;
    word_t   issue_a;
    word_t   issue_b;

    mdu_iq u_iq (
        .clk               (clk),
        .reset_i           (reset_i),
        .flush_i           (flush_i),
        .dispatch_valid_i  (dispatch_valid_i),
        .dispatch_op_i     (dispatch_op_i),
        .dispatch_rob_id_i (dispatch_rob_id_i),
        .src_data_i        (src_data_i),
        .src_tag_i         (src_tag_i),
        .src_ready_i       (src_ready_i),
        .cdb_valid_i       (cdb_valid_i),
        .cdb_rob_id_i      (cdb_rob_id_i),
        .cdb_data_i        (cdb_data_i),
        .issue_ready_i     (issue_ready),
        .dispatch_ready_o  (dispatch_ready_o),
        .issue_valid_o     (issue_valid),
        .issue_op_o        (issue_op),
        .issue_rob_id_o    (issue_rob_id),
        .issue_a_o         (issue_a),
        .issue_b_o         (issue_b)
    );

    mdu_unit u_unit (
        .clk             (clk),
        .reset_i         (reset_i),
        .flush_i         (flush_i),
        .issue_valid_i   (issue_valid),
        .issue_op_i      (issue_op),
        .issue_rob_id_i  (issue_rob_id),
        .issue_a_i       (issue_a),
        .issue_b_i       (issue_b),
        .result_ready_i  (result_ready_i),
        .issue_ready_o   (issue_ready),
        .result_valid_o  (result_valid_o),
        .result_rob_id_o (result_rob_id_o),
        .result_data_o   (result_data_o)
    );

endmodule

//--- source/mdu_unit.sv
`timescale 1ns/1ns

module mdu_unit (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             flush_i,
    input  logic             issue_valid_i,
    input  mdu_pkg::mdu_op_e issue_op_i,
    input  mdu_pkg::rob_id_t issue_rob_id_i,
    input  mdu_pkg::word_t   issue_a_i,
    input  mdu_pkg::word_t   issue_b_i,
    input  logic             result_ready_i,
    output logic             issue_ready_o,
    output logic             result_valid_o,
    output mdu_pkg::rob_id_t result_rob_id_o,
    output mdu_pkg::word_t   result_data_o
);
    import mdu_pkg::*;

    mdu_op_e op_q;
    rob_id_t rob_q;
    word_t   a_q;
    word_t   b_q;
    logic    busy_q;
    logic    go_q;
    logic    accept;

    // decode of the held opcode
    logic    is_div;
    logic    is_rem;
    logic    div_sgn;
    logic    mul_sgn;
    logic    div_zero;
    logic    div_ovf;
    word_t   special_res;

    assign accept        = issue_valid_i && !busy_q;
    assign issue_ready_o = !busy_q;

    always_comb begin
        is_div      = op_q inside {MDU_DIV, MDU_DIVU, MDU_REM, MDU_REMU};
        is_rem      = op_q inside {MDU_REM, MDU_REMU};
        div_sgn     = op_q inside {MDU_DIV, MDU_REM};
        mul_sgn     = op_q == MDU_MULH;
        div_zero    = b_q == '0;
        div_ovf     = div_sgn && a_q == {1'b1, {(XLEN-1){1'b0}}} && b_q == '1;
        // x/0 gives all ones, min/-1 gives min
        special_res = is_rem ? (div_zero ? a_q : '0) : (div_zero ? '1 : a_q);
    end

    // ------------------------------
    // multiplier
    // ------------------------------
    logic signed [XLEN:0]     mul_a;
    logic signed [XLEN:0]     mul_b;
    logic signed [2*XLEN+1:0] mul_full;
    logic [2*XLEN-1:0]        prod_q;
    logic                     mul_v_q;
    word_t                    mul_res;

    assign mul_a    = {mul_sgn && a_q[XLEN-1], a_q};
    assign mul_b    = {mul_sgn && b_q[XLEN-1], b_q};
    assign mul_full = (2*XLEN+2)'(mul_a) * (2*XLEN+2)'(mul_b);
    assign mul_res  = (op_q == MDU_MUL) ? prod_q[XLEN-1:0] : prod_q[2*XLEN-1:XLEN];

    // ------------------------------
    // restoring divider
    // ------------------------------
    div_state_e           div_state_q;
    logic [DIV_CNT_W-1:0] cnt_q;
    word_t                rem_q;
    word_t                quo_q;
    word_t                dvs_q;
    logic                 q_neg_q;
    logic                 r_neg_q;
    logic [XLEN:0]        rem_shift;
    logic [XLEN:0]        rem_diff;
    word_t                div_res;

    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign rem_diff  = rem_shift - {1'b0, dvs_q};
    assign div_res   = is_rem ? (r_neg_q ? -rem_q : rem_q) : (q_neg_q ? -quo_q : quo_q);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            div_state_q <= DIV_IDLE;
            cnt_q       <= '0;
        end else begin
            case (div_state_q)
                DIV_IDLE: begin
                    if (go_q && is_div && !div_zero && !div_ovf) begin
                        div_state_q <= DIV_RUN;
                        cnt_q       <= '0;
                    end
                end
                DIV_RUN: begin
                    cnt_q <= cnt_q + DIV_CNT_W'(1);
                    if (cnt_q == DIV_CNT_W'(DIV_STEPS - 1)) begin
                        div_state_q <= DIV_DONE;
                    end
                end
                default: begin
                    div_state_q <= DIV_IDLE;
                end
            endcase
        end
    end

    // magnitudes load while idle, one quotient bit per run cycle
    always_ff @(posedge clk) begin
        if (div_state_q == DIV_IDLE) begin
            rem_q   <= '0;
            quo_q   <= (div_sgn && a_q[XLEN-1]) ? -a_q : a_q;
            dvs_q   <= (div_sgn && b_q[XLEN-1]) ? -b_q : b_q;
            q_neg_q <= div_sgn && (a_q[XLEN-1] ^ b_q[XLEN-1]);
            r_neg_q <= div_sgn && a_q[XLEN-1];
        end else if (div_state_q == DIV_RUN) begin
            if (!rem_diff[XLEN]) begin
                rem_q <= rem_diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // ------------------------------
    // control and output register
    // ------------------------------
    logic  res_load;
    word_t res_n;

    always_comb begin
        res_load = mul_v_q || div_state_q == DIV_DONE || (go_q && is_div && (div_zero || div_ovf));
        if (mul_v_q) begin
            res_n = mul_res;
        end else if (div_state_q == DIV_DONE) begin
            res_n = div_res;
        end else begin
            res_n = special_res;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            busy_q         <= 1'b0;
            go_q           <= 1'b0;
            mul_v_q        <= 1'b0;
            result_valid_o <= 1'b0;
        end else begin
            go_q    <= accept;
            mul_v_q <= go_q && !is_div;
            // busy until the result has left
            if (accept) begin
                busy_q <= 1'b1;
            end else if (result_valid_o && result_ready_i) begin
                busy_q <= 1'b0;
            end
            if (res_load) begin
                result_valid_o <= 1'b1;
            end else if (result_ready_i) begin
                result_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= issue_op_i;
            rob_q <= issue_rob_id_i;
            a_q   <= issue_a_i;
            b_q   <= issue_b_i;
        end
        if (go_q) begin
            prod_q <= mul_full[2*XLEN-1:0];
        end
        if (res_load) begin
            result_rob_id_o <= rob_q;
            result_data_o   <= res_n;
        end
    end

endmodule

//--- source/mdu_iq.sv
`timescale 1ns/1ns

module mdu_iq (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             flush_i,
    input  logic             dispatch_valid_i [mdu_pkg::DISPATCH_W],
    input  mdu_pkg::mdu_op_e dispatch_op_i [mdu_pkg::DISPATCH_W],
    input  mdu_pkg::rob_id_t dispatch_rob_id_i [mdu_pkg::DISPATCH_W],
    input  mdu_pkg::word_t   src_data_i [mdu_pkg::DISPATCH_W][2],
    input  mdu_pkg::rob_id_t src_tag_i [mdu_pkg::DISPATCH_W][2],
    input  logic             src_ready_i [mdu_pkg::DISPATCH_W][2],
    input  logic             cdb_valid_i [mdu_pkg::CDB_W],
    input  mdu_pkg::rob_id_t cdb_rob_id_i [mdu_pkg::CDB_W],
    input  mdu_pkg::word_t   cdb_data_i [mdu_pkg::CDB_W],
    input  logic             issue_ready_i,
    output logic             dispatch_ready_o,
    output logic             issue_valid_o,
    output mdu_pkg::mdu_op_e issue_op_o,
    output mdu_pkg::rob_id_t issue_rob_id_o,
    output mdu_pkg::word_t   issue_a_o,
    output mdu_pkg::word_t   issue_b_o
);
    import mdu_pkg::*;

    logic [IQ_PTR_W-1:0] head_q;
    logic [IQ_PTR_W-1:0] tail_q;
    logic [IQ_PTR_W:0]   free_q;
    logic [IQ_PTR_W:0]   free_n;
    logic [IQ_PTR_W:0]   disp_cnt;
    logic                disp_v [DISPATCH_W];
    logic [IQ_PTR_W-1:0] slot_pos [DISPATCH_W];
    logic                can_load;
    logic                issue_fire;

    // per-entry connections
    logic    ent_init [IQ_SIZE];
    mdu_op_e ent_init_op [IQ_SIZE];
    rob_id_t ent_init_rob [IQ_SIZE];
    word_t   ent_init_data [IQ_SIZE][2];
    rob_id_t ent_init_tag [IQ_SIZE][2];
    logic    ent_init_rdy [IQ_SIZE][2];
    logic    ent_select [IQ_SIZE];
    logic    ent_valid [IQ_SIZE];
    logic    ent_ready [IQ_SIZE];
    mdu_op_e ent_op [IQ_SIZE];
    rob_id_t ent_rob [IQ_SIZE];
    word_t   ent_data [IQ_SIZE][2];

    // ------------------------------
    // dispatch steering
    // ------------------------------
    always_comb begin
        disp_cnt = '0;
        for (int d = 0; d < DISPATCH_W; d++) begin
            disp_v[d] = dispatch_valid_i[d] && dispatch_ready_o;
            // a lone later slot still takes the tail
            slot_pos[d] = tail_q + disp_cnt[IQ_PTR_W-1:0];
            disp_cnt    = disp_cnt + (IQ_PTR_W+1)'(disp_v[d]);
        end
    end

    always_comb begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            ent_init[i]      = 1'b0;
            ent_init_op[i]   = dispatch_op_i[0];
            ent_init_rob[i]  = dispatch_rob_id_i[0];
            ent_init_data[i] = src_data_i[0];
            ent_init_tag[i]  = src_tag_i[0];
            ent_init_rdy[i]  = src_ready_i[0];
            for (int d = 0; d < DISPATCH_W; d++) begin
                if (disp_v[d] && slot_pos[d] == IQ_PTR_W'(i)) begin
                    ent_init[i]      = 1'b1;
                    ent_init_op[i]   = dispatch_op_i[d];
                    ent_init_rob[i]  = dispatch_rob_id_i[d];
                    ent_init_data[i] = src_data_i[d];
                    ent_init_tag[i]  = src_tag_i[d];
                    ent_init_rdy[i]  = src_ready_i[d];
                end
            end
        end
    end

    // ------------------------------
    // in-order head issue
    // ------------------------------
    assign can_load   = !issue_valid_o || issue_ready_i;
    assign issue_fire = ent_valid[head_q] && ent_ready[head_q] && can_load;
    assign free_n     = free_q - disp_cnt + (IQ_PTR_W+1)'(issue_fire);

    always_comb begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            ent_select[i] = issue_fire && head_q == IQ_PTR_W'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            head_q           <= '0;
            tail_q           <= '0;
            free_q           <= (IQ_PTR_W+1)'(IQ_SIZE);
            dispatch_ready_o <= 1'b1;
        end else begin
            head_q           <= head_q + IQ_PTR_W'(issue_fire);
            tail_q           <= tail_q + disp_cnt[IQ_PTR_W-1:0];
            free_q           <= free_n;
            // room for a full dispatch pair next cycle
            dispatch_ready_o <= free_n >= (IQ_PTR_W+1)'(2);
        end
    end

    // operand register toward the unit
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            issue_valid_o <= 1'b0;
        end else if (can_load) begin
            issue_valid_o <= issue_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            issue_op_o     <= ent_op[head_q];
            issue_rob_id_o <= ent_rob[head_q];
            issue_a_o      <= ent_data[head_q][0];
            issue_b_o      <= ent_data[head_q][1];
        end
    end

    // ------------------------------
    // queue slots
    // ------------------------------
    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        iq_entry u_entry (
            .clk           (clk),
            .reset_i       (reset_i),
            .flush_i       (flush_i),
            .init_i        (ent_init[i]),
            .init_op_i     (ent_init_op[i]),
            .init_rob_id_i (ent_init_rob[i]),
            .init_data_i   (ent_init_data[i]),
            .init_tag_i    (ent_init_tag[i]),
            .init_ready_i  (ent_init_rdy[i]),
            .select_i      (ent_select[i]),
            .cdb_valid_i   (cdb_valid_i),
            .cdb_rob_id_i  (cdb_rob_id_i),
            .cdb_data_i    (cdb_data_i),
            .valid_o       (ent_valid[i]),
            .ready_o       (ent_ready[i]),
            .op_o          (ent_op[i]),
            .rob_id_o      (ent_rob[i]),
            .data_o        (ent_data[i])
        );
    end

endmodule

//--- source/iq_entry.sv
`timescale 1ns/1ns

module iq_entry (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             flush_i,
    input  logic             init_i,
    input  mdu_pkg::mdu_op_e init_op_i,
    input  mdu_pkg::rob_id_t init_rob_id_i,
    input  mdu_pkg::word_t   init_data_i [2],
    input  mdu_pkg::rob_id_t init_tag_i [2],
    input  logic             init_ready_i [2],
    input  logic             select_i,
    input  logic             cdb_valid_i [mdu_pkg::CDB_W],
    input  mdu_pkg::rob_id_t cdb_rob_id_i [mdu_pkg::CDB_W],
    input  mdu_pkg::word_t   cdb_data_i [mdu_pkg::CDB_W],
    output logic             valid_o,
    output logic             ready_o,
    output mdu_pkg::mdu_op_e op_o,
    output mdu_pkg::rob_id_t rob_id_o,
    output mdu_pkg::word_t   data_o [2]
);
    import mdu_pkg::*;

    logic    valid_q;
    mdu_op_e op_q;
    rob_id_t rob_id_q;
    word_t   data_q [2];
    rob_id_t tag_q [2];
    logic    rdy_q [2];

    // operand as seen this cycle
    word_t   src_data [2];
    rob_id_t src_tag [2];
    logic    src_rdy [2];
    word_t   data_n [2];
    logic    rdy_n [2];

    // ------------------------------
    // cdb tag match
    // ------------------------------
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            // new dispatch is matched before it lands
            src_data[s] = init_i ? init_data_i[s] : data_q[s];
            src_tag[s]  = init_i ? init_tag_i[s] : tag_q[s];
            src_rdy[s]  = init_i ? init_ready_i[s] : rdy_q[s];
            data_n[s]   = src_data[s];
            rdy_n[s]    = src_rdy[s];
            for (int k = 0; k < CDB_W; k++) begin
                if (!src_rdy[s] && cdb_valid_i[k] && cdb_rob_id_i[k] == src_tag[s]) begin
                    data_n[s] = cdb_data_i[k];
                    rdy_n[s]  = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (init_i) begin
            valid_q <= 1'b1;
        end else if (select_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (init_i) begin
            op_q     <= init_op_i;
            rob_id_q <= init_rob_id_i;
            tag_q    <= init_tag_i;
        end
        data_q <= data_n;
        rdy_q  <= rdy_n;
    end

    assign valid_o  = valid_q;
    assign ready_o  = valid_q && rdy_q[0] && rdy_q[1];
    assign op_o     = op_q;
    assign rob_id_o = rob_id_q;
    assign data_o   = data_q;

endmodule

//--- source/mdu_pkg.sv
package mdu_pkg;

    // ------------------------------
    // data and tag widths
    // ------------------------------
    localparam int XLEN      = 32;
    localparam int ROB_DEPTH = 32;
    localparam int ROB_ID_W  = $clog2(ROB_DEPTH);

    typedef logic [XLEN-1:0]     word_t;
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // ------------------------------
    // queue and bus sizes
    // ------------------------------
    localparam int IQ_SIZE    = 8;
    localparam int IQ_PTR_W   = 3;
    localparam int DISPATCH_W = 2;
    localparam int CDB_W      = 2;

    // one quotient bit per step
    localparam int DIV_STEPS = 32;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    // ------------------------------
    // opcodes and states
    // ------------------------------
    typedef enum logic [2:0] {
        MDU_MUL   = 3'd0,
        MDU_MULH  = 3'd1,
        MDU_MULHU = 3'd2,
        MDU_DIV   = 3'd4,
        MDU_DIVU  = 3'd5,
        MDU_REM   = 3'd6,
        MDU_REMU  = 3'd7
    } mdu_op_e;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

endpackage
